//--- hdl/rv_pkg.sv
package rv_pkg;

    //////////////////////////////
    // widths and sizes
    //////////////////////////////
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int DMEM_WORDS = 64;
    // word index bits of the data array
    localparam int DMEM_AW    = 6;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // funct3 codes
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_WORD = 3'b010;
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // addi x0, x0, 0
    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;

    //////////////////////////////
    // instruction formats
    //////////////////////////////
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, several views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    //////////////////////////////
    // control and stage registers
    //////////////////////////////
    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU, WB_LOAD, WB_RET
    } wb_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    reg_we;
        logic    mem_re;
        logic    mem_we;
        logic    is_branch;
        logic    br_ne;
        logic    is_jal;
        wb_sel_e wb_sel;
    } ctrl_t;

    typedef enum logic [1:0] {
        FWD_REG, FWD_EX_MEM, FWD_MEM_WB
    } fwd_sel_e;

    typedef struct packed {
        word_t  pc;
        instr_u instr;
        logic   pred_taken;
    } if_id_t;

    typedef struct packed {
        word_t  pc;
        instr_u instr;
        word_t  rs1_data;
        word_t  rs2_data;
        word_t  imm;
        ctrl_t  ctrl;
        logic   pred_taken;
    } id_ex_t;

    typedef struct packed {
        instr_u instr;
        word_t  alu_out;
        word_t  store_data;
        word_t  ret_addr;
        ctrl_t  ctrl;
    } ex_mem_t;

    typedef struct packed {
        word_t    pc;
        reg_idx_t rd;
        word_t    alu_out;
        word_t    load_data;
        word_t    ret_addr;
        ctrl_t    ctrl;
    } mem_wb_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        word_t    data;
    } retire_t;

    // bubble contents of the front stages
    localparam if_id_t IF_ID_NOP = {{XLEN{1'b0}}, NOP_INSTR, 1'b0};
    localparam id_ex_t ID_EX_NOP =
        {{XLEN{1'b0}}, NOP_INSTR, {(3 * XLEN + $bits(ctrl_t) + 1){1'b0}}};
    localparam ex_mem_t EX_MEM_NOP = {NOP_INSTR, {(3 * XLEN + $bits(ctrl_t)){1'b0}}};

endpackage

//--- hdl/rv_alu.sv
`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
    input  alu_op_e i_op,
    input  word_t   i_a,
    input  word_t   i_b,
    output word_t   o_result,
    output logic    o_equal
);

    logic lt_signed;

    assign lt_signed = $signed(i_a) < $signed(i_b);

    always_comb
    begin
        case (i_op)
            ALU_ADD: o_result = i_a + i_b;
            ALU_SUB: o_result = i_a - i_b;
            ALU_AND: o_result = i_a & i_b;
            ALU_OR:  o_result = i_a | i_b;
            ALU_XOR: o_result = i_a ^ i_b;
            // set-less-than result in bit 0
            ALU_SLT: o_result = {{(XLEN-1){1'b0}}, lt_signed};
            default: o_result = '0;
        endcase
    end

    // beq / bne condition
    assign o_equal = (i_a == i_b);

endmodule

//--- hdl/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t i_rs1,
    input  reg_idx_t i_rs2,
    input  reg_idx_t i_rd,
    input  logic     i_we,
    input  word_t    i_wdata,
    output word_t    o_rs1_data,
    output word_t    o_rs2_data
);

    word_t regs [2**REG_ADDR_W];
    logic  wr_valid;

    // x0 never takes a write
    assign wr_valid = i_we && (i_rd != '0);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            regs <= '{default: '0};
        else if (wr_valid)
            regs[i_rd] <= i_wdata;
    end

    // same-cycle write shows through on the read ports
    assign o_rs1_data = (wr_valid && (i_rd == i_rs1)) ? i_wdata : regs[i_rs1];
    assign o_rs2_data = (wr_valid && (i_rd == i_rs2)) ? i_wdata : regs[i_rs2];

endmodule

//--- hdl/rv_decode.sv
`timescale 1ns/1ps

module rv_decode import rv_pkg::*; (
    input  instr_u i_instr,
    output ctrl_t  o_ctrl,
    output word_t  o_imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = i_instr.r_fmt.opcode;
    assign funct3 = i_instr.r_fmt.funct3;

    always_comb
    begin
        // anything unknown falls through as a nop
        o_ctrl = '0;
        o_imm  = '0;
        case (opcode)
            OPC_OP:
            begin
                o_ctrl.reg_we = 1'b1;
                case (funct3)
                    F3_ADD:  o_ctrl.alu_op = i_instr.r_fmt.funct7[5] ? ALU_SUB : ALU_ADD;
                    F3_AND:  o_ctrl.alu_op = ALU_AND;
                    F3_OR:   o_ctrl.alu_op = ALU_OR;
                    F3_XOR:  o_ctrl.alu_op = ALU_XOR;
                    F3_SLT:  o_ctrl.alu_op = ALU_SLT;
                    default: o_ctrl.reg_we = 1'b0;
                endcase
            end
            OPC_OP_IMM:
            begin
                // addi only
                if (funct3 == F3_ADD)
                begin
                    o_ctrl.use_imm = 1'b1;
                    o_ctrl.reg_we  = 1'b1;
                end
                o_imm = {{20{i_instr.i_fmt.imm[11]}}, i_instr.i_fmt.imm};
            end
            OPC_LOAD:
            begin
                if (funct3 == F3_WORD)
                begin
                    o_ctrl.use_imm = 1'b1;
                    o_ctrl.reg_we  = 1'b1;
                    o_ctrl.mem_re  = 1'b1;
                    o_ctrl.wb_sel  = WB_LOAD;
                end
                o_imm = {{20{i_instr.i_fmt.imm[11]}}, i_instr.i_fmt.imm};
            end
            OPC_STORE:
            begin
                if (funct3 == F3_WORD)
                begin
                    o_ctrl.use_imm = 1'b1;
                    o_ctrl.mem_we  = 1'b1;
                end
                o_imm = {{20{i_instr.s_fmt.imm_hi[6]}}, i_instr.s_fmt.imm_hi,
                         i_instr.s_fmt.imm_lo};
            end
            OPC_BRANCH:
            begin
                // alu only supplies the equality flag here
                o_ctrl.is_branch = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
                o_ctrl.br_ne     = (funct3 == F3_BNE);
                o_ctrl.alu_op    = ALU_SUB;
                o_imm = {{19{i_instr.b_fmt.imm12}}, i_instr.b_fmt.imm12, i_instr.b_fmt.imm11,
                         i_instr.b_fmt.imm10_5, i_instr.b_fmt.imm4_1, 1'b0};
            end
            OPC_JAL:
            begin
                o_ctrl.reg_we = 1'b1;
                o_ctrl.is_jal = 1'b1;
                o_ctrl.wb_sel = WB_RET;
                o_imm = {{11{i_instr.j_fmt.imm20}}, i_instr.j_fmt.imm20,
                         i_instr.j_fmt.imm19_12, i_instr.j_fmt.imm11,
                         i_instr.j_fmt.imm10_1, 1'b0};
            end
            default:
            begin
                o_ctrl = '0;
            end
        endcase
    end

endmodule

//--- hdl/rv_hazard_unit.sv
`timescale 1ns/1ps

module rv_hazard_unit import rv_pkg::*; (
    input  reg_idx_t i_ex_rs1,
    input  reg_idx_t i_ex_rs2,
    input  reg_idx_t i_mem_rd,
    input  logic     i_mem_we,
    input  reg_idx_t i_wb_rd,
    input  logic     i_wb_we,
    input  reg_idx_t i_id_rs1,
    input  reg_idx_t i_id_rs2,
    input  reg_idx_t i_ex_rd,
    input  logic     i_ex_mem_re,
    output fwd_sel_e o_fwd_a,
    output fwd_sel_e o_fwd_b,
    output logic     o_stall
);

    // youngest producer first and x0 never forwarded
    function automatic fwd_sel_e pick_src(reg_idx_t rs, reg_idx_t mem_rd, logic mem_we,
                                          reg_idx_t wb_rd, logic wb_we);
        if (mem_we && (mem_rd != '0) && (mem_rd == rs))
            return FWD_EX_MEM;
        else if (wb_we && (wb_rd != '0) && (wb_rd == rs))
            return FWD_MEM_WB;
        else
            return FWD_REG;
    endfunction

    //////////////////////////////
    // forwarding select
    //////////////////////////////
    assign o_fwd_a = pick_src(i_ex_rs1, i_mem_rd, i_mem_we, i_wb_rd, i_wb_we);
    assign o_fwd_b = pick_src(i_ex_rs2, i_mem_rd, i_mem_we, i_wb_rd, i_wb_we);

    //////////////////////////////
    // load-use detect
    //////////////////////////////
    always_comb
    begin
        // load data only exists after the memory stage
        o_stall = i_ex_mem_re && (i_ex_rd != '0) &&
                  ((i_ex_rd == i_id_rs1) || (i_ex_rd == i_id_rs2));
    end

endmodule

//--- hdl/rv_branch_predictor.sv
`timescale 1ns/1ps

module rv_branch_predictor import rv_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic i_resolve,
    input  logic i_taken,
    output logic o_predict_taken
);

    // 00 strong not-taken .. 11 strong taken
    logic [1:0] cnt;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            cnt <= 2'b11;
        end
        else if (i_resolve)
        begin
            // saturate at both ends
            if (i_taken && (cnt != 2'b11))
                cnt <= cnt + 2'd1;
            else if (!i_taken && (cnt != 2'b00))
                cnt <= cnt - 2'd1;
        end
    end

    // upper half of the range guesses taken
    assign o_predict_taken = cnt[1];

endmodule

//--- hdl/rv_data_mem.sv
`timescale 1ns/1ps

module rv_data_mem import rv_pkg::*; (
    input  logic  clk,
    input  logic  i_we,
    input  word_t i_addr,
    input  word_t i_wdata,
    output word_t o_rdata
);

    word_t                mem [DMEM_WORDS];
    logic [DMEM_AW-1:0]   word_idx;

    // byte address to word index, upper bits wrap
    assign word_idx = i_addr[DMEM_AW+1:2];

    always_ff @(posedge clk)
    begin
        if (i_we)
            mem[word_idx] <= i_wdata;
    end

    // read is combinational, same cycle as the address
    assign o_rdata = mem[word_idx];

    // sw only, so every store is word aligned
    a_store_aligned : assert property (@(posedge clk) i_we |-> i_addr[1:0] == 2'b00);

endmodule

//--- hdl/rv_pipe_core.sv
`timescale 1ns/1ps

module rv_pipe_core import rv_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    output word_t   o_imem_addr,
    input  word_t   i_imem_data,
    output retire_t o_retire,
    output logic    o_flush
);

    word_t   pc;
    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;

    // decode side
    ctrl_t    dec_ctrl;
    word_t    dec_imm;
    word_t    rf_rs1_data;
    word_t    rf_rs2_data;
    logic     pred_taken;
    logic     id_redirect;
    logic     stall;

    // execute side
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    word_t    ex_fwd_val;
    word_t    fwd_a_val;
    word_t    fwd_b_val;
    word_t    alu_b;
    word_t    alu_out;
    logic     alu_equal;
    logic     br_taken;
    logic     mispredict;
    word_t    fix_pc;

    // memory and writeback
    word_t    dmem_rdata;
    word_t    wb_data;

    function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val, word_t mem_val,
                                      word_t wb_val);
        case (sel)
            FWD_EX_MEM: return mem_val;
            FWD_MEM_WB: return wb_val;
            default:    return reg_val;
        endcase
    endfunction

    //////////////////////////////
    // fetch and decode
    //////////////////////////////
    assign o_imem_addr = pc;

    rv_decode u_decode (
        .i_instr (if_id.instr),
        .o_ctrl  (dec_ctrl),
        .o_imm   (dec_imm)
    );

    rv_regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_rs1      (if_id.instr.r_fmt.rs1),
        .i_rs2      (if_id.instr.r_fmt.rs2),
        .i_rd       (mem_wb.rd),
        .i_we       (mem_wb.ctrl.reg_we),
        .i_wdata    (wb_data),
        .o_rs1_data (rf_rs1_data),
        .o_rs2_data (rf_rs2_data)
    );

    // guess sampled at fetch, acted on in decode
    rv_branch_predictor u_predictor (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_resolve       (id_ex.ctrl.is_branch),
        .i_taken         (br_taken),
        .o_predict_taken (pred_taken)
    );

    // jal always, branches only on a taken guess
    assign id_redirect = dec_ctrl.is_jal | (dec_ctrl.is_branch & if_id.pred_taken);

    rv_hazard_unit u_hazard (
        .i_ex_rs1    (id_ex.instr.r_fmt.rs1),
        .i_ex_rs2    (id_ex.instr.r_fmt.rs2),
        .i_mem_rd    (ex_mem.instr.r_fmt.rd),
        .i_mem_we    (ex_mem.ctrl.reg_we),
        .i_wb_rd     (mem_wb.rd),
        .i_wb_we     (mem_wb.ctrl.reg_we),
        .i_id_rs1    (if_id.instr.r_fmt.rs1),
        .i_id_rs2    (if_id.instr.r_fmt.rs2),
        .i_ex_rd     (id_ex.instr.r_fmt.rd),
        .i_ex_mem_re (id_ex.ctrl.mem_re),
        .o_fwd_a     (fwd_a),
        .o_fwd_b     (fwd_b),
        .o_stall     (stall)
    );

    //////////////////////////////
    // execute
    //////////////////////////////
    // jal in ex/mem forwards its link value
    assign ex_fwd_val = (ex_mem.ctrl.wb_sel == WB_RET) ? ex_mem.ret_addr : ex_mem.alu_out;
    assign fwd_a_val  = fwd_mux(fwd_a, id_ex.rs1_data, ex_fwd_val, wb_data);
    assign fwd_b_val  = fwd_mux(fwd_b, id_ex.rs2_data, ex_fwd_val, wb_data);
    assign alu_b      = id_ex.ctrl.use_imm ? id_ex.imm : fwd_b_val;

    rv_alu u_alu (
        .i_op     (id_ex.ctrl.alu_op),
        .i_a      (fwd_a_val),
        .i_b      (alu_b),
        .o_result (alu_out),
        .o_equal  (alu_equal)
    );

    assign br_taken   = id_ex.ctrl.is_branch & (alu_equal ^ id_ex.ctrl.br_ne);
    assign mispredict = id_ex.ctrl.is_branch & (br_taken != id_ex.pred_taken);
    assign fix_pc     = br_taken ? id_ex.pc + id_ex.imm : id_ex.pc + 32'd4;
    assign o_flush    = mispredict;

    //////////////////////////////
    // memory and writeback
    //////////////////////////////
    rv_data_mem u_dmem (
        .clk     (clk),
        .i_we    (ex_mem.ctrl.mem_we),
        .i_addr  (ex_mem.alu_out),
        .i_wdata (ex_mem.store_data),
        .o_rdata (dmem_rdata)
    );

    always_comb
    begin
        case (mem_wb.ctrl.wb_sel)
            WB_LOAD: wb_data = mem_wb.load_data;
            WB_RET:  wb_data = mem_wb.ret_addr;
            default: wb_data = mem_wb.alu_out;
        endcase
    end

    assign o_retire = '{valid: mem_wb.ctrl.reg_we && (mem_wb.rd != '0),
                        pc: mem_wb.pc, rd: mem_wb.rd, data: wb_data};

    //////////////////////////////
    // pc and stage registers
    //////////////////////////////
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            pc     <= '0;
            if_id  <= IF_ID_NOP;
            id_ex  <= ID_EX_NOP;
            ex_mem <= EX_MEM_NOP;
            mem_wb <= '0;
        end
        else
        begin
            // back half never stops
            ex_mem <= '{instr: id_ex.instr, alu_out: alu_out, store_data: fwd_b_val,
                        ret_addr: id_ex.pc + 32'd4, ctrl: id_ex.ctrl};
            // pc recovered from the link value
            mem_wb <= '{pc: ex_mem.ret_addr - 32'd4, rd: ex_mem.instr.r_fmt.rd,
                        alu_out: ex_mem.alu_out, load_data: dmem_rdata,
                        ret_addr: ex_mem.ret_addr, ctrl: ex_mem.ctrl};
            if (stall)
            begin
                // hold pc and if/id, bubble into execute
                id_ex <= ID_EX_NOP;
            end
            else if (mispredict)
            begin
                pc    <= fix_pc;
                if_id <= IF_ID_NOP;
                id_ex <= ID_EX_NOP;
            end
            else
            begin
                id_ex <= '{pc: if_id.pc, instr: if_id.instr, rs1_data: rf_rs1_data,
                           rs2_data: rf_rs2_data, imm: dec_imm, ctrl: dec_ctrl,
                           pred_taken: if_id.pred_taken & dec_ctrl.is_branch};
                if (id_redirect)
                begin
                    // squash the word fetched behind the jump
                    pc    <= if_id.pc + dec_imm;
                    if_id <= IF_ID_NOP;
                end
                else
                begin
                    pc    <= pc + 32'd4;
                    if_id <= '{pc: pc, instr: i_imem_data, pred_taken: pred_taken};
                end
            end
        end
    end

    // only a decoded branch can be resolved wrong
    a_flush_on_branch : assert property (@(posedge clk) disable iff (!rst_n)
        o_flush |-> id_ex.instr.r_fmt.opcode == OPC_BRANCH);

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    input  logic i_rst_req,
    output logic o_clk,
    output logic o_rst_n
);

    localparam int HALF_PERIOD = 20;
    localparam int RST_CYCLES  = 4;

    // edges of reset still to come
    int rst_left = RST_CYCLES;

    initial
    begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    // a request restarts the reset window
    always @(posedge o_clk)
    begin
        if (i_rst_req)
            rst_left <= RST_CYCLES;
        else if (rst_left != 0)
            rst_left <= rst_left - 1;
    end

    assign o_rst_n = (rst_left == 0);

endmodule

//--- bench/tb_rv_pipe_core.sv
`timescale 1ns/1ps

module tb_rv_pipe_core import rv_pkg::*; ();

    localparam int CLK_PERIOD    = 40;
    localparam int ROM_WORDS     = 64;
    localparam int ROM_AW        = 6;
    localparam int NUM_TESTS     = 6;
    localparam int TEST_BUDGET   = 80;
    localparam int SETTLE_CYCLES = 10;
    // reset pulse plus load overhead per test, and some slack
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (TEST_BUDGET + SETTLE_CYCLES + 8) + 40;
    localparam int SUB_F7 = 32'h20;

    logic    clk;
    logic    rst_n;
    logic    rst_req;
    word_t   imem_addr;
    word_t   imem_data;
    retire_t retire;
    logic    flush;

    word_t   rom [ROM_WORDS];
    word_t   prog [$];
    retire_t expect_q [$];
    retire_t got_q [$];
    int      flush_cnt;
    int      errors;
    int      failed_tests;
    integer  seed;

    tb_clock clk_gen (
        .i_rst_req (rst_req),
        .o_clk     (clk),
        .o_rst_n   (rst_n)
    );

    rv_pipe_core dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .o_imem_addr (imem_addr),
        .i_imem_data (imem_data),
        .o_retire    (retire),
        .o_flush     (flush)
    );

    // instruction rom answers nop outside the array
    assign imem_data = (imem_addr < ROM_WORDS * 4) ? rom[imem_addr[ROM_AW+1:2]] : NOP_INSTR;

    //////////////////////////////
    // instruction encoders
    //////////////////////////////
    function automatic word_t r_type(input int f7, input int rs2, input int rs1,
                                     input logic [2:0] f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
    endfunction

    function automatic word_t i_type(input int imm, input int rs1, input logic [2:0] f3,
                                     input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic word_t addi(input int rd, input int rs1, input int imm);
        return i_type(imm, rs1, F3_ADD, rd, OPC_OP_IMM);
    endfunction

    function automatic word_t lw(input int rd, input int rs1, input int imm);
        return i_type(imm, rs1, F3_WORD, rd, OPC_LOAD);
    endfunction

    function automatic word_t sw(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], F3_WORD, imm[4:0], OPC_STORE};
    endfunction

    // branch offset in bytes with bit 0 dropped
    function automatic word_t b_type(input int imm, input int rs2, input int rs1,
                                     input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t j_type(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
    endfunction

    //////////////////////////////
    // retire monitor
    //////////////////////////////
    // sampled mid-cycle once outputs settle
    always @(negedge clk)
    begin
        if (!rst_n)
        begin
            got_q.delete();
            flush_cnt = 0;
        end
        else
        begin
            if (retire.valid)
                got_q.push_back(retire);
            if (flush)
                flush_cnt++;
        end
    end

    task automatic expect_ret(input int pc, input int rd, input word_t data);
        retire_t r;
        r.valid = 1'b1;
        r.pc    = pc;
        r.rd    = rd[4:0];
        r.data  = data;
        expect_q.push_back(r);
    endtask

    task automatic check_retire(input int idx, input retire_t got, input retire_t exp);
        assert ((got.pc == exp.pc) && (got.rd == exp.rd) && (got.data == exp.data))
        else
        begin
            $display("Fail at %0t ns: retirement %0d gave pc %h x%0d=%h, expected pc %h x%0d=%h",
                     $time, idx, got.pc, got.rd, got.data, exp.pc, exp.rd, exp.data);
            errors++;
        end
    endtask

    // reset, load, run to the expected retire count, compare
    task automatic run_program(input int budget);
        int cycles;
        @(posedge clk);
        rst_req <= 1'b1;
        @(posedge clk);
        rst_req <= 1'b0;
        @(posedge clk);
        // core is held in reset here
        for (int i = 0; i < ROM_WORDS; i++)
            rom[i[ROM_AW-1:0]] <= (i < prog.size()) ? prog[i] : NOP_INSTR;
        while (!rst_n)
            @(posedge clk);
        cycles = 0;
        while ((got_q.size() < expect_q.size()) && (cycles < budget))
        begin
            @(posedge clk);
            cycles++;
        end
        assert (got_q.size() >= expect_q.size())
        else
        begin
            $display("retirements stopped: only %0d of %0d instructions retired in %0d cycles",
                     got_q.size(), expect_q.size(), budget);
            errors++;
        end
        // a few more cycles to catch extra or duplicate retirements
        repeat (SETTLE_CYCLES)
            @(posedge clk);
        assert (got_q.size() == expect_q.size())
        else
        begin
            $display("Fail at %0t ns: %0d instructions retired, expected %0d",
                     $time, got_q.size(), expect_q.size());
            errors++;
        end
        for (int i = 0; i < expect_q.size(); i++)
        begin
            if (i < got_q.size())
                check_retire(i, got_q[i], expect_q[i]);
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        if (errors == err_start)
        begin
            $display("%s: ok", name);
        end
        else
        begin
            $display("%s: FAILED with %0d errors", name, errors - err_start);
            failed_tests++;
        end
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////
    // dependent chain forwarding from ex/mem and mem/wb
    task automatic alu_chain();
        int    err_start;
        int    ia;
        int    ib;
        word_t a;
        word_t b;
        word_t c;
        word_t d;
        word_t e;
        word_t f;
        word_t g;
        err_start = errors;
        prog.delete();
        expect_q.delete();
        ia = $random(seed);
        ib = $random(seed);
        a  = {{20{ia[11]}}, ia[11:0]};
        b  = {{20{ib[11]}}, ib[11:0]};
        c  = a + b;
        d  = c - a;
        e  = d & c;
        f  = e | d;
        g  = f ^ e;
        prog.push_back(addi(1, 0, ia));
        prog.push_back(addi(2, 0, ib));
        prog.push_back(r_type(0, 2, 1, F3_ADD, 3));
        prog.push_back(r_type(SUB_F7, 1, 3, F3_ADD, 4));
        prog.push_back(r_type(0, 3, 4, F3_AND, 5));
        prog.push_back(r_type(0, 4, 5, F3_OR, 6));
        prog.push_back(r_type(0, 5, 6, F3_XOR, 7));
        prog.push_back(r_type(0, 1, 7, F3_SLT, 8));
        prog.push_back(r_type(0, 2, 1, F3_SLT, 9));
        expect_ret(0, 1, a);
        expect_ret(4, 2, b);
        expect_ret(8, 3, c);
        expect_ret(12, 4, d);
        expect_ret(16, 5, e);
        expect_ret(20, 6, f);
        expect_ret(24, 7, g);
        expect_ret(28, 8, ($signed(g) < $signed(a)) ? 32'd1 : 32'd0);
        expect_ret(32, 9, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        run_program(TEST_BUDGET);
        report_test("test 1 alu chain", err_start);
    endtask

    task automatic store_then_load();
        int err_start;
        err_start = errors;
        prog.delete();
        expect_q.delete();
        prog.push_back(addi(1, 0, 32'h123));
        prog.push_back(addi(2, 0, 40));
        prog.push_back(sw(1, 2, 8));
        prog.push_back(lw(3, 2, 8));
        prog.push_back(addi(4, 0, 32'h55));
        prog.push_back(r_type(0, 4, 3, F3_ADD, 5));
        expect_ret(0, 1, 32'h123);
        expect_ret(4, 2, 32'd40);
        expect_ret(12, 3, 32'h123);
        expect_ret(16, 4, 32'h55);
        expect_ret(20, 5, 32'h178);
        run_program(TEST_BUDGET);
        report_test("test 2 store then load", err_start);
    endtask

    // load-use on rs1 then on rs2
    task automatic load_use_stall();
        int err_start;
        err_start = errors;
        prog.delete();
        expect_q.delete();
        prog.push_back(addi(1, 0, 32'h2a5));
        prog.push_back(sw(1, 0, 0));
        prog.push_back(lw(2, 0, 0));
        prog.push_back(r_type(0, 2, 2, F3_ADD, 3));
        prog.push_back(r_type(SUB_F7, 2, 3, F3_ADD, 4));
        prog.push_back(lw(5, 0, 0));
        prog.push_back(r_type(0, 5, 1, F3_ADD, 6));
        expect_ret(0, 1, 32'h2a5);
        expect_ret(8, 2, 32'h2a5);
        expect_ret(12, 3, 32'h54a);
        expect_ret(16, 4, 32'h2a5);
        expect_ret(20, 5, 32'h2a5);
        expect_ret(24, 6, 32'h54a);
        run_program(TEST_BUDGET);
        report_test("test 3 load-use stall", err_start);
    endtask

    task automatic branches_and_jal();
        int err_start;
        err_start = errors;
        prog.delete();
        expect_q.delete();
        prog.push_back(addi(1, 0, 5));
        prog.push_back(addi(2, 0, 5));
        // beq taken skips pc 12
        prog.push_back(b_type(8, 2, 1, F3_BEQ));
        prog.push_back(addi(3, 0, 1));
        prog.push_back(b_type(8, 2, 1, F3_BNE));
        prog.push_back(addi(4, 0, 2));
        prog.push_back(b_type(8, 0, 1, F3_BEQ));
        prog.push_back(addi(5, 0, 3));
        // bne taken skips pc 36
        prog.push_back(b_type(8, 0, 1, F3_BNE));
        prog.push_back(addi(6, 0, 4));
        prog.push_back(j_type(8, 7));
        prog.push_back(addi(8, 0, 5));
        prog.push_back(addi(9, 7, 1));
        expect_ret(0, 1, 32'd5);
        expect_ret(4, 2, 32'd5);
        expect_ret(20, 4, 32'd2);
        expect_ret(28, 5, 32'd3);
        expect_ret(40, 7, 32'd44);
        expect_ret(48, 9, 32'd45);
        run_program(TEST_BUDGET);
        report_test("test 4 branches and jal", err_start);
    endtask

    // counter starts strongly taken, so only the exit mispredicts
    task automatic countdown_loop();
        int err_start;
        err_start = errors;
        prog.delete();
        expect_q.delete();
        prog.push_back(addi(1, 0, 4));
        prog.push_back(addi(2, 2, 1));
        prog.push_back(addi(1, 1, -1));
        prog.push_back(b_type(-8, 0, 1, F3_BNE));
        prog.push_back(addi(3, 2, 0));
        expect_ret(0, 1, 32'd4);
        for (int k = 1; k <= 4; k++)
        begin
            expect_ret(4, 2, k);
            expect_ret(8, 1, 4 - k);
        end
        expect_ret(16, 3, 32'd4);
        run_program(TEST_BUDGET);
        assert (flush_cnt == 1)
        else
        begin
            $display("Fail at %0t ns: o_flush pulsed %0d times, expected 1", $time, flush_cnt);
            errors++;
        end
        report_test("test 5 countdown loop", err_start);
    endtask

    task automatic x0_discard();
        int err_start;
        err_start = errors;
        prog.delete();
        expect_q.delete();
        prog.push_back(addi(0, 0, 32'h77));
        prog.push_back(addi(1, 0, 9));
        prog.push_back(r_type(0, 1, 1, F3_ADD, 0));
        // x0 read right behind a write to it
        prog.push_back(r_type(0, 1, 0, F3_ADD, 2));
        prog.push_back(r_type(0, 0, 0, F3_OR, 3));
        expect_ret(4, 1, 32'd9);
        expect_ret(12, 2, 32'd9);
        expect_ret(16, 3, 32'd0);
        run_program(TEST_BUDGET);
        report_test("test 6 x0 writes", err_start);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial
    begin
        seed         = 32'hba2a_461f;
        errors       = 0;
        failed_tests = 0;
        rst_req <= 1'b0;
        for (int i = 0; i < ROM_WORDS; i++)
            rom[i[ROM_AW-1:0]] <= NOP_INSTR;
        alu_chain();
        store_then_load();
        load_use_stall();
        branches_and_jal();
        countdown_loop();
        x0_discard();
        $display("summary: %0d tests run, %0d failed, %0d check errors",
                 NUM_TESTS, failed_tests, errors);
        if ((failed_tests == 0) && (errors == 0))
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    // hard stop if the sequence hangs
    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

endmodule

//--- vlog.f
hdl/rv_pkg.sv
hdl/rv_alu.sv
hdl/rv_regfile.sv
hdl/rv_decode.sv
hdl/rv_hazard_unit.sv
hdl/rv_branch_predictor.sv
hdl/rv_data_mem.sv
hdl/rv_pipe_core.sv
bench/tb_clock.sv
bench/tb_rv_pipe_core.sv

//--- Makefile
TOP = tb_rv_pipe_core
OBJ = obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir $(OBJ)
	@out="$$(./$(OBJ)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf $(OBJ)
